/* logic/dpath_pkg.sv */
/*
  Datapath package for the dual-issue core
  Word widths, reset vector, mux select codes, ALU functions and control structs
*/
package dpath_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;

  localparam word_t RESET_VECTOR = 32'h0008_0000;
  localparam int    INST_BYTES   = 4;

  localparam int NREGS  = 32;
  localparam int REG_AW = 5;

  typedef logic [REG_AW-1:0] reg_addr_t;

  // ------------------------------------------------------------------------
  // Mux select codes
  // ------------------------------------------------------------------------

  typedef enum logic [1:0] {
    PC_PLUS8   = 2'd0,
    PC_BRANCH  = 2'd1,
    PC_JUMP    = 2'd2,
    PC_JUMPREG = 2'd3
  } pc_sel_e;

  typedef enum logic [2:0] {
    BYP_RF      = 3'd0,
    BYP_ALU_A_X = 3'd1,
    BYP_ALU_B_X = 3'd2,
    BYP_WB_A_W  = 3'd3,
    BYP_WB_B_W  = 3'd4
  } byp_sel_e;

  typedef enum logic [1:0] {
    OP0_BYP  = 2'd0,
    OP0_PC   = 2'd1,
    OP0_PC4  = 2'd2,
    OP0_ZERO = 2'd3
  } op0_sel_e;

  typedef enum logic [2:0] {
    OP1_BYP    = 3'd0,
    OP1_SHAMT  = 3'd1,
    OP1_IMM_U  = 3'd2,
    OP1_IMM_SB = 3'd3,
    OP1_IMM_I  = 3'd4,
    OP1_IMM_S  = 3'd5,
    OP1_ZERO   = 3'd6
  } op1_sel_e;

  typedef enum logic [3:0] {
    ADD  = 4'd0,
    SUB  = 4'd1,
    SLL  = 4'd2,
    SLT  = 4'd3,
    SLTU = 4'd4,
    XOR  = 4'd5,
    SRL  = 4'd6,
    SRA  = 4'd7,
    OR   = 4'd8,
    AND  = 4'd9
  } alu_fn_e;

  // ------------------------------------------------------------------------
  // Control and status bundles
  // ------------------------------------------------------------------------

  // Op fields are used in D, fn in X
  typedef struct packed {
    byp_sel_e byp0;
    byp_sel_e byp1;
    op0_sel_e op0;
    op1_sel_e op1;
    alu_fn_e  fn;
  } lane_ctrl_t;

  typedef struct packed {
    logic      wen;
    reg_addr_t waddr;
  } wb_ctrl_t;

  typedef struct packed {
    logic f;
    logic d;
    logic x;
    logic w;
  } stall_t;

  typedef struct packed {
    logic eq;
    logic ne;
    logic lt;
    logic ltu;
    logic ge;
    logic geu;
  } branch_cond_t;

endpackage

/* logic/inst_pkg.sv */
/*
  Instruction word views and the immediate bundle for RV32I decode
*/
package inst_pkg;

  import dpath_pkg::*;

  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // SB immediates reuse this split
  typedef struct packed {
    logic [6:0] imm_hi;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  // UJ immediates are scrambled out of the same upper 20 bits
  typedef struct packed {
    logic [19:0] imm;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    u_fmt_t u_fmt;
  } inst_u;

  typedef struct packed {
    word_t imm_i;
    word_t imm_s;
    word_t imm_sb;
    word_t imm_u;
    word_t imm_uj;
    word_t shamt;
  } imm_set_t;

endpackage

/* logic/pc_gen.sv */
/*
  PC generation: next-PC mux, fetch and decode PC registers,
  lane steering and the jump, jump-register and branch targets
*/
`timescale 1ns/1ps

module pc_gen
  import dpath_pkg::*;
  import inst_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  pc_sel_e  pc_sel,
  input  logic     steer,
  input  stall_t   stall,
  input  imm_set_t imm_a,
  input  word_t    jr_base,
  input  word_t    branch_targ_x,
  output word_t    imem_addr0,
  output word_t    imem_addr1,
  output word_t    pc_a,
  output word_t    pc_a4,
  output word_t    pc_b,
  output word_t    pc_b4,
  output word_t    branch_targ_d
);

  word_t pc_f;
  word_t pc_d;
  word_t pc_d4;
  word_t pc_d8;
  word_t next_pc;
  word_t jump_targ;
  word_t jr_sum;

  // ------------------------------------------------------------------------
  // P stage
  // ------------------------------------------------------------------------

  always_comb begin
    case (pc_sel)
      PC_PLUS8:   next_pc = pc_f + word_t'(2 * INST_BYTES);
      PC_BRANCH:  next_pc = branch_targ_x;
      PC_JUMP:    next_pc = jump_targ;
      default:    next_pc = {jr_sum[XLEN-1:1], 1'b0};
    endcase
  end

  // Fetch request goes out before the F register loads
  assign imem_addr0 = reset ? RESET_VECTOR : next_pc;
  assign imem_addr1 = imem_addr0 + word_t'(INST_BYTES);

  always_ff @(posedge clk) begin
    if (reset) begin
      pc_f <= RESET_VECTOR;
    end else if (!stall.f) begin
      pc_f <= next_pc;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc_d <= RESET_VECTOR;
    end else if (!stall.d) begin
      pc_d <= pc_f;
    end
  end

  // ------------------------------------------------------------------------
  // D stage
  // ------------------------------------------------------------------------

  assign pc_d4 = pc_d + word_t'(INST_BYTES);
  assign pc_d8 = pc_d + word_t'(2 * INST_BYTES);

  // Steer swaps which lane holds the older instruction
  assign pc_a  = steer ? pc_d4 : pc_d;
  assign pc_a4 = steer ? pc_d8 : pc_d4;
  assign pc_b  = steer ? pc_d  : pc_d4;
  assign pc_b4 = steer ? pc_d4 : pc_d8;

  assign jump_targ     = pc_a + imm_a.imm_uj;
  assign jr_sum        = jr_base + imm_a.imm_i;
  assign branch_targ_d = pc_a + imm_a.imm_sb;

  a_fetch_aligned: assert property (
    @(posedge clk) disable iff (reset) pc_f[1:0] == 2'b00
  ) else $error("fetch PC is not word aligned");

endmodule

/* logic/inst_fields.sv */
/*
  Per-lane instruction field decode
  Register sources plus sign-extended immediates and the shift amount
*/
`timescale 1ns/1ps

module inst_fields
  import dpath_pkg::*;
  import inst_pkg::*;
(
  input  word_t     inst,
  output reg_addr_t rs1,
  output reg_addr_t rs2,
  output imm_set_t  imm
);

  inst_u iw;

  assign iw = inst;

  assign rs1 = iw.r_fmt.rs1;
  assign rs2 = iw.r_fmt.rs2;

  assign imm.imm_i = {{(XLEN-12){iw.i_fmt.imm[11]}}, iw.i_fmt.imm};
  assign imm.imm_s = {{(XLEN-12){iw.s_fmt.imm_hi[6]}}, iw.s_fmt.imm_hi, iw.s_fmt.imm_lo};

  // Branch offset with bit 11 in imm_lo[0]
  assign imm.imm_sb = {{(XLEN-13){iw.s_fmt.imm_hi[6]}}, iw.s_fmt.imm_hi[6],
                       iw.s_fmt.imm_lo[0], iw.s_fmt.imm_hi[5:0],
                       iw.s_fmt.imm_lo[4:1], 1'b0};

  assign imm.imm_u = {iw.u_fmt.imm, 12'b0};

  // Jump offset imm[20|10:1|11|19:12] sits in bits 31:12
  assign imm.imm_uj = {{(XLEN-21){iw.u_fmt.imm[19]}}, iw.u_fmt.imm[19],
                       iw.u_fmt.imm[7:0], iw.u_fmt.imm[8],
                       iw.u_fmt.imm[18:9], 1'b0};

  assign imm.shamt = {{(XLEN-REG_AW){1'b0}}, iw.r_fmt.rs2};

endmodule

/* logic/regfile.sv */
/*
  Register file, 32 x 32 with four read and two write ports
  Reads are combinational and x0 reads as zero
*/
`timescale 1ns/1ps

module regfile
  import dpath_pkg::*;
(
  input  logic                clk,
  input  reg_addr_t [3:0]     raddr,
  output word_t     [3:0]     rdata,
  input  wb_ctrl_t            wb_a,
  input  wb_ctrl_t            wb_b,
  input  word_t               wdata_a,
  input  word_t               wdata_b
);

  word_t mem [NREGS];

  // Lane B is written last so it wins on a shared address
  always_ff @(posedge clk) begin
    if (wb_a.wen) begin
      mem[wb_a.waddr] <= wdata_a;
    end
    if (wb_b.wen) begin
      mem[wb_b.waddr] <= wdata_b;
    end
  end

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      if (raddr[i] == '0) begin
        rdata[i] = '0;
      end else begin
        rdata[i] = mem[raddr[i]];
      end
    end
  end

endmodule

/* logic/operand_sel.sv */
/*
  Operand selection for one lane
  Bypass muxes pick the freshest value, operand muxes add PC, immediates and zero
*/
`timescale 1ns/1ps

module operand_sel
  import dpath_pkg::*;
  import inst_pkg::*;
(
  input  lane_ctrl_t ctrl,
  input  word_t      rf0,
  input  word_t      rf1,
  input  word_t      pc,
  input  word_t      pc4,
  input  imm_set_t   imm,
  input  word_t      alu_a_x,
  input  word_t      alu_b_x,
  input  word_t      wb_a_w,
  input  word_t      wb_b_w,
  output word_t      byp0,
  output word_t      op0,
  output word_t      op1
);

  word_t byp1;

  function automatic word_t byp_mux(byp_sel_e sel, word_t rf, word_t ax, word_t bx,
                                    word_t aw, word_t bw);
    word_t res;
    case (sel)
      BYP_RF:      res = rf;
      BYP_ALU_A_X: res = ax;
      BYP_ALU_B_X: res = bx;
      BYP_WB_A_W:  res = aw;
      BYP_WB_B_W:  res = bw;
      default:     res = '0;
    endcase
    return res;
  endfunction

  assign byp0 = byp_mux(ctrl.byp0, rf0, alu_a_x, alu_b_x, wb_a_w, wb_b_w);
  assign byp1 = byp_mux(ctrl.byp1, rf1, alu_a_x, alu_b_x, wb_a_w, wb_b_w);

  always_comb begin
    case (ctrl.op0)
      OP0_BYP: op0 = byp0;
      OP0_PC:  op0 = pc;
      OP0_PC4: op0 = pc4;
      default: op0 = '0;
    endcase
  end

  always_comb begin
    case (ctrl.op1)
      OP1_BYP:    op1 = byp1;
      OP1_SHAMT:  op1 = imm.shamt;
      OP1_IMM_U:  op1 = imm.imm_u;
      OP1_IMM_SB: op1 = imm.imm_sb;
      OP1_IMM_I:  op1 = imm.imm_i;
      OP1_IMM_S:  op1 = imm.imm_s;
      default:    op1 = '0;
    endcase
  end

  // Codes above BYP_WB_B_W name no source
  a_byp_legal: assert final ($isunknown({ctrl.byp0, ctrl.byp1}) ||
                             (ctrl.byp0 <= BYP_WB_B_W && ctrl.byp1 <= BYP_WB_B_W))
    else $error("illegal bypass select");

endmodule

/* logic/exec_stage.sv */
/*
  Execute and writeback: D-to-X and X-to-W registers,
  the two lane ALUs and lane A's branch conditions
*/
`timescale 1ns/1ps

module exec_stage
  import dpath_pkg::*;
(
  input  logic         clk,
  input  stall_t       stall,
  input  alu_fn_e      fn_a,
  input  alu_fn_e      fn_b,
  input  word_t        op_a0,
  input  word_t        op_a1,
  input  word_t        op_b0,
  input  word_t        op_b1,
  input  word_t        branch_targ_d,
  output word_t        alu_a_x,
  output word_t        alu_b_x,
  output word_t        branch_targ_x,
  output word_t        wb_a_w,
  output word_t        wb_b_w,
  output branch_cond_t branch_cond
);

  word_t op_a0_x;
  word_t op_a1_x;
  word_t op_b0_x;
  word_t op_b1_x;
  logic  diff_signs;

  function automatic word_t alu(alu_fn_e fn, word_t in0, word_t in1);
    word_t res;
    case (fn)
      ADD:     res = in0 + in1;
      SUB:     res = in0 - in1;
      SLL:     res = in0 << in1[4:0];
      SLT:     res = {{(XLEN-1){1'b0}}, $signed(in0) < $signed(in1)};
      SLTU:    res = {{(XLEN-1){1'b0}}, in0 < in1};
      XOR:     res = in0 ^ in1;
      SRL:     res = in0 >> in1[4:0];
      SRA:     res = word_t'($signed(in0) >>> in1[4:0]);
      OR:      res = in0 | in1;
      AND:     res = in0 & in1;
      default: res = '0;
    endcase
    return res;
  endfunction

  // ------------------------------------------------------------------------
  // X <- D
  // ------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!stall.x) begin
      op_a0_x       <= op_a0;
      op_a1_x       <= op_a1;
      op_b0_x       <= op_b0;
      op_b1_x       <= op_b1;
      branch_targ_x <= branch_targ_d;
    end
  end

  assign alu_a_x = alu(fn_a, op_a0_x, op_a1_x);
  assign alu_b_x = alu(fn_b, op_b0_x, op_b1_x);

  // Lane A runs SUB for branches; on differing signs the operand MSBs decide
  assign diff_signs = op_a0_x[XLEN-1] ^ op_a1_x[XLEN-1];

  assign branch_cond.eq  = (alu_a_x == '0);
  assign branch_cond.ne  = (alu_a_x != '0);
  assign branch_cond.lt  = diff_signs ? op_a0_x[XLEN-1] : alu_a_x[XLEN-1];
  assign branch_cond.ltu = diff_signs ? op_a1_x[XLEN-1] : alu_a_x[XLEN-1];
  assign branch_cond.ge  = diff_signs ? op_a1_x[XLEN-1] : ~alu_a_x[XLEN-1];
  assign branch_cond.geu = diff_signs ? op_a0_x[XLEN-1] : ~alu_a_x[XLEN-1];

  // ------------------------------------------------------------------------
  // W <- X
  // ------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!stall.w) begin
      wb_a_w <= alu_a_x;
      wb_b_w <= alu_b_x;
    end
  end

  // A result latched into W must come from a defined ALU function
  a_fn_known: assert property (
    @(posedge clk) !stall.w |-> (fn_a <= AND) && (fn_b <= AND)
  ) else $error("unknown ALU function entering W");

endmodule

/* logic/dual_dpath.sv */
/*
  Dual-issue RV32I datapath, stages P, F, D, X and W
  Control comes in as per-stage selects and stall levels
*/
`timescale 1ns/1ps

module dual_dpath
  import dpath_pkg::*;
  import inst_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  pc_sel_e      pc_sel,
  input  logic         steer,
  input  word_t        inst_a,
  input  word_t        inst_b,
  input  lane_ctrl_t   ctrl_a,
  input  lane_ctrl_t   ctrl_b,
  input  wb_ctrl_t     wb_a,
  input  wb_ctrl_t     wb_b,
  input  stall_t       stall,
  output word_t        imem_addr0,
  output word_t        imem_addr1,
  output branch_cond_t branch_cond,
  output word_t        csr_data
);

  reg_addr_t       rs1_a;
  reg_addr_t       rs2_a;
  reg_addr_t       rs1_b;
  reg_addr_t       rs2_b;
  imm_set_t        imm_a;
  imm_set_t        imm_b;
  word_t     [3:0] rf_rdata;
  word_t           pc_a;
  word_t           pc_a4;
  word_t           pc_b;
  word_t           pc_b4;
  word_t           branch_targ_d;
  word_t           branch_targ_x;
  word_t           byp0_a;
  word_t           op0_a;
  word_t           op1_a;
  word_t           op0_b;
  word_t           op1_b;
  word_t           alu_a_x;
  word_t           alu_b_x;
  word_t           wb_a_w;
  word_t           wb_b_w;

  assign csr_data = wb_a_w;

  pc_gen i_pc_gen (
    .clk           (clk),
    .reset         (reset),
    .pc_sel        (pc_sel),
    .steer         (steer),
    .stall         (stall),
    .imm_a         (imm_a),
    .jr_base       (byp0_a),
    .branch_targ_x (branch_targ_x),
    .imem_addr0    (imem_addr0),
    .imem_addr1    (imem_addr1),
    .pc_a          (pc_a),
    .pc_a4         (pc_a4),
    .pc_b          (pc_b),
    .pc_b4         (pc_b4),
    .branch_targ_d (branch_targ_d)
  );

  inst_fields i_fields_a (.inst(inst_a), .rs1(rs1_a), .rs2(rs2_a), .imm(imm_a));
  inst_fields i_fields_b (.inst(inst_b), .rs1(rs1_b), .rs2(rs2_b), .imm(imm_b));

  // Ports 0-1 serve lane A, 2-3 lane B
  regfile i_regfile (
    .clk     (clk),
    .raddr   ({rs2_b, rs1_b, rs2_a, rs1_a}),
    .rdata   (rf_rdata),
    .wb_a    (wb_a),
    .wb_b    (wb_b),
    .wdata_a (wb_a_w),
    .wdata_b (wb_b_w)
  );

  operand_sel i_opsel_a (
    .ctrl    (ctrl_a),
    .rf0     (rf_rdata[0]),
    .rf1     (rf_rdata[1]),
    .pc      (pc_a),
    .pc4     (pc_a4),
    .imm     (imm_a),
    .alu_a_x (alu_a_x),
    .alu_b_x (alu_b_x),
    .wb_a_w  (wb_a_w),
    .wb_b_w  (wb_b_w),
    .byp0    (byp0_a),
    .op0     (op0_a),
    .op1     (op1_a)
  );

  operand_sel i_opsel_b (
    .ctrl    (ctrl_b),
    .rf0     (rf_rdata[2]),
    .rf1     (rf_rdata[3]),
    .pc      (pc_b),
    .pc4     (pc_b4),
    .imm     (imm_b),
    .alu_a_x (alu_a_x),
    .alu_b_x (alu_b_x),
    .wb_a_w  (wb_a_w),
    .wb_b_w  (wb_b_w),
    .byp0    (),
    .op0     (op0_b),
    .op1     (op1_b)
  );

  exec_stage i_exec (
    .clk           (clk),
    .stall         (stall),
    .fn_a          (ctrl_a.fn),
    .fn_b          (ctrl_b.fn),
    .op_a0         (op0_a),
    .op_a1         (op1_a),
    .op_b0         (op0_b),
    .op_b1         (op1_b),
    .branch_targ_d (branch_targ_d),
    .alu_a_x       (alu_a_x),
    .alu_b_x       (alu_b_x),
    .branch_targ_x (branch_targ_x),
    .wb_a_w        (wb_a_w),
    .wb_b_w        (wb_b_w),
    .branch_cond   (branch_cond)
  );

endmodule

/* bench/dual_dpath_tb.sv */
/*
  Testbench for the dual-issue datapath
  Directed tests for fetch, ALU, register file, bypass and branch paths
*/
`timescale 1ns/1ps

module dual_dpath_tb
  import dpath_pkg::*;
();

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 8;
  localparam int ALU_OPS      = 20;
  localparam int BR_PAIRS     = 16;

  // Cycle budget per test, summed for the watchdog
  localparam int FETCH_BUDGET = RESET_CYCLES + 16;
  localparam int ALU_BUDGET   = ALU_OPS * 3 + 4;
  localparam int RF_BUDGET    = 7 * 3 + 4;
  localparam int BYP_BUDGET   = 10;
  localparam int BR_BUDGET    = BR_PAIRS * 4 + 4;
  localparam int TARG_BUDGET  = 2 * 8 + 4;
  localparam int TOTAL_CYCLES = FETCH_BUDGET + ALU_BUDGET + RF_BUDGET + BYP_BUDGET +
                                BR_BUDGET + TARG_BUDGET;

  localparam lane_ctrl_t IDLE_CTRL = '{byp0: BYP_RF, byp1: BYP_RF, op0: OP0_ZERO,
                                       op1: OP1_ZERO, fn: ADD};
  localparam wb_ctrl_t   NO_WB     = '{wen: 1'b0, waddr: 5'd0};
  localparam stall_t     NO_STALL  = '{f: 1'b0, d: 1'b0, x: 1'b0, w: 1'b0};
  localparam stall_t     F_STALL   = '{f: 1'b1, d: 1'b0, x: 1'b0, w: 1'b0};
  localparam stall_t     FD_STALL  = '{f: 1'b1, d: 1'b1, x: 1'b0, w: 1'b0};

  logic         clk;
  logic         reset;
  pc_sel_e      pc_sel;
  logic         steer;
  word_t        inst_a;
  word_t        inst_b;
  lane_ctrl_t   ctrl_a;
  lane_ctrl_t   ctrl_b;
  wb_ctrl_t     wb_a;
  wb_ctrl_t     wb_b;
  stall_t       stall;
  word_t        imem_addr0;
  word_t        imem_addr1;
  branch_cond_t branch_cond;
  word_t        csr_data;
  word_t        rng_state;

  dual_dpath i_dut (
    .clk         (clk),
    .reset       (reset),
    .pc_sel      (pc_sel),
    .steer       (steer),
    .inst_a      (inst_a),
    .inst_b      (inst_b),
    .ctrl_a      (ctrl_a),
    .ctrl_b      (ctrl_b),
    .wb_a        (wb_a),
    .wb_b        (wb_b),
    .stall       (stall),
    .imem_addr0  (imem_addr0),
    .imem_addr1  (imem_addr1),
    .branch_cond (branch_cond),
    .csr_data    (csr_data)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------

  function automatic word_t xorshift32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic expect_equal(input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("mismatch at %0t ns: %s got 0x%08h expected 0x%08h",
                                  $time, what, got, exp));
    end
  endtask

  function automatic lane_ctrl_t make_ctrl(byp_sel_e b0, byp_sel_e b1, op0_sel_e o0,
                                           op1_sel_e o1, alu_fn_e fn);
    lane_ctrl_t c;
    c.byp0 = b0;
    c.byp1 = b1;
    c.op0  = o0;
    c.op1  = o1;
    c.fn   = fn;
    return c;
  endfunction

  function automatic wb_ctrl_t write_to(reg_addr_t r);
    wb_ctrl_t w;
    w.wen   = 1'b1;
    w.waddr = r;
    return w;
  endfunction

  // RV32I encodings
  function automatic word_t encode_i(logic [11:0] imm, reg_addr_t rs1);
    return {imm, rs1, 3'b000, 5'd0, 7'h13};
  endfunction

  function automatic word_t encode_u(word_t value);
    return {value[31:12], 5'd0, 7'h37};
  endfunction

  function automatic word_t encode_r(reg_addr_t rs2, reg_addr_t rs1);
    return {7'd0, rs2, rs1, 3'b000, 5'd0, 7'h33};
  endfunction

  function automatic word_t encode_j(logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], 5'd0, 7'h6f};
  endfunction

  function automatic word_t encode_b(logic [12:0] off);
    return {off[12], off[10:5], 5'd0, 5'd0, 3'b000, off[4:1], off[11], 7'h63};
  endfunction

  function automatic word_t sext_i(logic [11:0] imm);
    return {{20{imm[11]}}, imm};
  endfunction

  function automatic word_t upper_of(word_t v);
    return {v[31:12], 12'h000};
  endfunction

  // Reference ALU
  function automatic word_t alu_model(alu_fn_e fn, word_t a, word_t b);
    logic [4:0] sh;
    word_t      res;
    sh = b[4:0];
    case (fn)
      ADD:     res = a + b;
      SUB:     res = a + ~b + 32'd1;
      SLL:     res = a << sh;
      SLT:     res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      SLTU:    res = (a < b) ? 32'd1 : 32'd0;
      XOR:     res = a ^ b;
      SRL:     res = a >> sh;
      SRA:     res = (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
      OR:      res = a | b;
      default: res = a & b;
    endcase
    return res;
  endfunction

  // One item per lane from D to W; the write port is armed during W
  task automatic run_through_pipe(input word_t ia, input lane_ctrl_t ca, input word_t ib,
                                  input lane_ctrl_t cb, input wb_ctrl_t wa,
                                  input wb_ctrl_t wbb);
    @(posedge clk);
    inst_a <= ia;
    ctrl_a <= ca;
    inst_b <= ib;
    ctrl_b <= cb;
    wb_a   <= NO_WB;
    wb_b   <= NO_WB;
    repeat (2) @(posedge clk);
    wb_a <= wa;
    wb_b <= wbb;
    @(negedge clk);
  endtask

  // --------------------------------------------------------------------------
  // Tests
  // --------------------------------------------------------------------------

  task automatic test_fetch();
    word_t exp;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    expect_equal("imem_addr0 in reset", imem_addr0, RESET_VECTOR);
    expect_equal("imem_addr1 in reset", imem_addr1, RESET_VECTOR + 32'd4);
    @(posedge clk);
    reset <= 1'b0;
    exp = RESET_VECTOR;
    for (int i = 0; i < 12; i++) begin
      @(negedge clk);
      expect_equal("imem_addr0 sequential", imem_addr0, exp + 32'd8);
      expect_equal("imem_addr1 sequential", imem_addr1, exp + 32'd12);
      @(posedge clk);
      if (!stall.f) begin
        exp = exp + 32'd8;
      end
      stall <= (i >= 3 && i < 7) ? F_STALL : NO_STALL;
    end
  endtask

  task automatic test_alu();
    word_t    r;
    word_t    operand;
    alu_fn_e  fn;
    op1_sel_e sel;
    for (int i = 0; i < ALU_OPS; i++) begin
      r  = xorshift32();
      fn = alu_fn_e'(4'(i % 10));
      if ((i % 2) == 1) begin
        operand = upper_of(r);
        sel     = OP1_IMM_U;
      end else begin
        operand = sext_i(r[31:20]);
        sel     = OP1_IMM_I;
      end
      run_through_pipe(r, make_ctrl(BYP_RF, BYP_RF, OP0_ZERO, sel, fn), '0, IDLE_CTRL,
                       NO_WB, NO_WB);
      expect_equal($sformatf("lane A %s", fn.name()), csr_data, alu_model(fn, '0, operand));
    end
  endtask

  task automatic test_regfile();
    lane_ctrl_t load_u;
    lane_ctrl_t read_rs1;
    word_t      a5;
    word_t      b6;
    word_t      a7;
    word_t      b7;
    load_u   = make_ctrl(BYP_RF, BYP_RF, OP0_ZERO, OP1_IMM_U, ADD);
    read_rs1 = make_ctrl(BYP_RF, BYP_RF, OP0_BYP, OP1_ZERO, ADD);
    a5 = upper_of(xorshift32());
    b6 = upper_of(xorshift32());
    a7 = upper_of(xorshift32());
    b7 = upper_of(xorshift32());
    if (b7 == a7) begin
      b7 = b7 ^ 32'h0000_1000;
    end
    run_through_pipe(encode_u(a5), load_u, encode_u(b6), load_u, write_to(5'd5),
                     write_to(5'd6));
    // Both lanes hit x7
    run_through_pipe(encode_u(a7), load_u, encode_u(b7), load_u, write_to(5'd7),
                     write_to(5'd7));
    run_through_pipe(encode_u(32'hfff0_0000), load_u, '0, IDLE_CTRL, write_to(5'd0), NO_WB);
    run_through_pipe(encode_r(5'd0, 5'd5), read_rs1, '0, IDLE_CTRL, NO_WB, NO_WB);
    expect_equal("x5 written by lane A", csr_data, a5);
    run_through_pipe(encode_r(5'd0, 5'd6), read_rs1, '0, IDLE_CTRL, NO_WB, NO_WB);
    expect_equal("x6 written by lane B", csr_data, b6);
    run_through_pipe(encode_r(5'd0, 5'd7), read_rs1, '0, IDLE_CTRL, NO_WB, NO_WB);
    expect_equal("x7 after same-address write", csr_data, b7);
    run_through_pipe(encode_r(5'd0, 5'd0), read_rs1, '0, IDLE_CTRL, NO_WB, NO_WB);
    expect_equal("x0 read", csr_data, '0);
  endtask

  task automatic test_bypass();
    word_t       rnd;
    logic [11:0] ia1;
    logic [11:0] ib2;
    logic [11:0] ic2;
    word_t       r2;
    word_t       r3;
    word_t       r4;
    rnd = xorshift32();
    ia1 = rnd[31:20];
    rnd = xorshift32();
    ib2 = rnd[31:20];
    rnd = xorshift32();
    ic2 = rnd[31:20];
    r2  = alu_model(XOR, sext_i(ia1), sext_i(ic2));
    r3  = alu_model(SUB, sext_i(ib2), sext_i(ia1));
    r4  = alu_model(XOR, sext_i(ib2), r3);
    @(posedge clk);
    inst_a <= encode_i(ia1, 5'd0);
    ctrl_a <= make_ctrl(BYP_RF, BYP_RF, OP0_ZERO, OP1_IMM_I, ADD);
    @(posedge clk);
    inst_a <= encode_i(ic2, 5'd0);
    ctrl_a <= make_ctrl(BYP_ALU_A_X, BYP_RF, OP0_BYP, OP1_IMM_I, ADD);
    inst_b <= encode_i(ib2, 5'd0);
    ctrl_b <= make_ctrl(BYP_RF, BYP_RF, OP0_ZERO, OP1_IMM_I, ADD);
    @(posedge clk);
    ctrl_a <= make_ctrl(BYP_ALU_B_X, BYP_WB_A_W, OP0_BYP, OP1_BYP, XOR);
    ctrl_b <= IDLE_CTRL;
    @(negedge clk);
    expect_equal("bypass op1", csr_data, sext_i(ia1));
    @(posedge clk);
    ctrl_a <= make_ctrl(BYP_WB_B_W, BYP_ALU_A_X, OP0_BYP, OP1_BYP, SUB);
    @(negedge clk);
    expect_equal("bypass from ALU A in X", csr_data, r2);
    @(posedge clk);
    ctrl_a <= make_ctrl(BYP_RF, BYP_RF, OP0_ZERO, OP1_ZERO, XOR);
    @(negedge clk);
    expect_equal("bypass from ALU B in X and WB A", csr_data, r3);
    @(posedge clk);
    ctrl_a <= IDLE_CTRL;
    @(negedge clk);
    expect_equal("bypass from WB B and ALU A in X", csr_data, r4);
  endtask

  task automatic test_branch_cond();
    word_t      xr;
    word_t      yr;
    word_t      x;
    word_t      y;
    logic       lt;
    logic [5:0] cond_exp;
    for (int i = 0; i < BR_PAIRS; i++) begin
      xr = xorshift32();
      yr = ((i % 4) == 0) ? xr : xorshift32();
      x  = upper_of(xr) + sext_i(xr[11:0]);
      y  = upper_of(yr) + sext_i(yr[11:0]);
      lt = $signed(x) < $signed(y);
      cond_exp = {x == y, x != y, lt, x < y, !lt, !(x < y)};
      // Build each operand as upper bits plus a signed low part
      @(posedge clk);
      inst_a <= encode_u(xr);
      ctrl_a <= make_ctrl(BYP_RF, BYP_RF, OP0_ZERO, OP1_IMM_U, ADD);
      inst_b <= encode_u(yr);
      ctrl_b <= make_ctrl(BYP_RF, BYP_RF, OP0_ZERO, OP1_IMM_U, ADD);
      @(posedge clk);
      inst_a <= encode_i(xr[11:0], 5'd0);
      ctrl_a <= make_ctrl(BYP_ALU_A_X, BYP_RF, OP0_BYP, OP1_IMM_I, ADD);
      inst_b <= encode_i(yr[11:0], 5'd0);
      ctrl_b <= make_ctrl(BYP_ALU_B_X, BYP_RF, OP0_BYP, OP1_IMM_I, ADD);
      @(posedge clk);
      ctrl_a <= make_ctrl(BYP_ALU_A_X, BYP_ALU_B_X, OP0_BYP, OP1_BYP, ADD);
      ctrl_b <= IDLE_CTRL;
      @(posedge clk);
      ctrl_a <= make_ctrl(BYP_RF, BYP_RF, OP0_ZERO, OP1_ZERO, SUB);
      @(negedge clk);
      expect_equal($sformatf("branch_cond for %h vs %h", x, y), {26'd0, branch_cond},
                   {26'd0, cond_exp});
    end
  endtask

  task automatic test_targets();
    word_t       rnd;
    word_t       pca;
    word_t       base;
    logic [20:0] joff;
    logic [11:0] jimm;
    logic [12:0] boff;
    for (int s = 0; s < 2; s++) begin
      rnd  = xorshift32();
      joff = {rnd[31:12], 1'b0};
      rnd  = xorshift32();
      jimm = rnd[31:20];
      rnd  = xorshift32();
      boff = {rnd[31:20], 1'b0};
      base = upper_of(xorshift32());
      pca  = (s == 1) ? RESET_VECTOR + 32'd4 : RESET_VECTOR;
      // Reset gives known PCs, then F and D hold
      @(posedge clk);
      reset  <= 1'b1;
      pc_sel <= PC_PLUS8;
      steer  <= (s == 1);
      @(posedge clk);
      reset <= 1'b0;
      stall <= FD_STALL;
      @(posedge clk);
      inst_a <= encode_j(joff);
      pc_sel <= PC_JUMP;
      @(negedge clk);
      expect_equal("jump target", imem_addr0, pca + {{11{joff[20]}}, joff});
      expect_equal("jump target plus 4", imem_addr1, pca + {{11{joff[20]}}, joff} + 32'd4);
      @(posedge clk);
      inst_a <= encode_u(base);
      ctrl_a <= make_ctrl(BYP_RF, BYP_RF, OP0_ZERO, OP1_IMM_U, ADD);
      pc_sel <= PC_PLUS8;
      @(posedge clk);
      inst_a <= encode_i(jimm, 5'd0);
      ctrl_a <= make_ctrl(BYP_ALU_A_X, BYP_RF, OP0_BYP, OP1_ZERO, ADD);
      pc_sel <= PC_JUMPREG;
      @(negedge clk);
      expect_equal("jump-register target", imem_addr0,
                   (base + sext_i(jimm)) & 32'hffff_fffe);
      @(posedge clk);
      inst_a <= encode_b(boff);
      ctrl_a <= IDLE_CTRL;
      pc_sel <= PC_PLUS8;
      @(posedge clk);
      inst_a <= '0;
      pc_sel <= PC_BRANCH;
      @(negedge clk);
      expect_equal("branch target", imem_addr0, pca + {{19{boff[12]}}, boff});
      @(posedge clk);
      stall  <= NO_STALL;
      pc_sel <= PC_PLUS8;
      steer  <= 1'b0;
    end
  endtask

  // --------------------------------------------------------------------------
  // Main sequence and watchdog
  // --------------------------------------------------------------------------

  initial begin
    rng_state = 32'hc013_822b;
    clk       = 1'b0;
    reset     = 1'b1;
    pc_sel    = PC_PLUS8;
    steer     = 1'b0;
    inst_a    = '0;
    inst_b    = '0;
    ctrl_a    = IDLE_CTRL;
    ctrl_b    = IDLE_CTRL;
    wb_a      = NO_WB;
    wb_b      = NO_WB;
    stall     = NO_STALL;
    test_fetch();
    test_alu();
    test_regfile();
    test_bypass();
    test_branch_cond();
    test_targets();
    $display("** PASS **");
    $finish;
  end

  initial begin
    #(2 * TOTAL_CYCLES * CLK_PERIOD);
    stop_with_failure("timeout: the tests did not finish within their cycle budget");
  end

endmodule

/* all.f */
logic/dpath_pkg.sv
logic/inst_pkg.sv
logic/pc_gen.sv
logic/inst_fields.sv
logic/regfile.sv
logic/operand_sel.sv
logic/exec_stage.sv
logic/dual_dpath.sv
bench/dual_dpath_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the dual_dpath testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module dual_dpath_tb -o dual_dpath_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/dual_dpath_tb
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi
exit 0
